// ==== verilog/tlb_macros.svh ====
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// Table geometry.
`define TLB_NUM 16
`define TLB_INDEX_W 4

// Address fields.
`define VPN2_W 19  // Virtual address bits 31 to 13.
`define PFN_W 20
`define ASID_W 8

`endif

// ==== verilog/tlb_pkg.sv ====
`include "tlb_macros.svh"

package tlb_pkg;

  // One page of a pair.
  typedef struct packed {
    logic [`PFN_W-1:0] pfn;
    logic [1:0]        cache;  // Stored only.
    logic              dirty;  // Page is writable.
    logic              valid;
  } entry_t;

  typedef struct packed {
    logic [`VPN2_W-1:0] virtual_page_number;
    logic [`ASID_W-1:0] asid;
    logic               is_global;
    entry_t             even_page;
    entry_t             odd_page;
  } tlb_entry_t;

  typedef struct packed {
    logic [`VPN2_W-1:0] virtual_page_number;
    logic [`ASID_W-1:0] asid;
    logic               is_even_page;  // Virtual address bit 12 is zero.
  } search_request_t;

  typedef struct packed {
    logic                    found;
    logic [`TLB_INDEX_W-1:0] index;
    entry_t                  entry;
  } search_result_t;

endpackage

// ==== verilog/mmu_pkg.sv ====
package mmu_pkg;

  typedef enum logic [1:0] {
    access_fetch,
    access_load,
    access_store
  } access_t;

  typedef enum logic [1:0] {
    exc_none,
    exc_refill,
    exc_invalid,
    exc_modified
  } exception_t;

  // Values written to the command register.
  typedef enum logic [1:0] {
    cmd_idle  = 2'd0,
    cmd_tlbr  = 2'd1,
    cmd_tlbwi = 2'd2,
    cmd_tlbp  = 2'd3
  } command_t;

  typedef struct packed {
    logic        valid;
    access_t     access;
    logic [31:0] vaddr;
  } translate_request_t;

  typedef struct packed {
    logic        valid;
    exception_t  exception;
    logic [31:0] paddr;  // Zero unless exception is none.
  } translate_result_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_request_t;

  typedef enum logic [1:0] {
    state_idle,
    state_probing,
    state_acking
  } manager_state_t;

endpackage

// ==== verilog/tlb.sv ====
`include "tlb_macros.svh"

module tlb (
  input  logic                     clock,
  input  logic                     rst,
  input  tlb_pkg::search_request_t fetch_search,
  input  tlb_pkg::search_request_t data_search,
  output tlb_pkg::search_result_t  fetch_found,
  output tlb_pkg::search_result_t  data_found,
  input  logic                     write_enabled,
  input  logic [`TLB_INDEX_W-1:0]  write_index,
  input  tlb_pkg::tlb_entry_t      write_data,
  input  logic [`TLB_INDEX_W-1:0]  read_index,
  output tlb_pkg::tlb_entry_t      read_data
);
  tlb_pkg::tlb_entry_t entries [`TLB_NUM];
  logic [`TLB_NUM-1:0] fetch_hits;
  logic [`TLB_NUM-1:0] data_hits;

  function automatic logic [`TLB_NUM-1:0] match_hits(
    input tlb_pkg::search_request_t req,
    input tlb_pkg::tlb_entry_t      slots [`TLB_NUM]
  );
    logic [`TLB_NUM-1:0] hits;
    for (int i = 0; i < `TLB_NUM; i++) begin
      hits[i] = req.virtual_page_number == slots[i].virtual_page_number &&
                (req.asid == slots[i].asid || slots[i].is_global);
    end
    return hits;
  endfunction

  // Index and page are OR-combined over all hits; at most one is set.
  function automatic tlb_pkg::search_result_t select_hit(
    input tlb_pkg::search_request_t req,
    input logic [`TLB_NUM-1:0]      hits,
    input tlb_pkg::tlb_entry_t      slots [`TLB_NUM]
  );
    tlb_pkg::search_result_t res;
    tlb_pkg::entry_t         page;
    res = '0;
    res.found = |hits;
    for (int i = 0; i < `TLB_NUM; i++) begin
      page = req.is_even_page ? slots[i].even_page : slots[i].odd_page;
      res.index = res.index | ({`TLB_INDEX_W{hits[i]}} & i[`TLB_INDEX_W-1:0]);
      res.entry = res.entry | ({$bits(tlb_pkg::entry_t){hits[i]}} & page);
    end
    return res;
  endfunction

  assign fetch_hits = match_hits(fetch_search, entries);
  assign data_hits = match_hits(data_search, entries);
  assign fetch_found = select_hit(fetch_search, fetch_hits, entries);
  assign data_found = select_hit(data_search, data_hits, entries);

  assign read_data = entries[read_index];  // Combinational read.

  always_ff @(posedge clock) begin
    if (write_enabled) begin
      entries[write_index] <= write_data;
    end
  end

  // Software keeps mappings unique; the match logic relies on it.
  a_fetch_unique: assert property (@(posedge clock) disable iff (rst)
    !$isunknown(fetch_hits) |-> $onehot0(fetch_hits))
    else $error("tlb: fetch search matched more than one entry");

  a_data_unique: assert property (@(posedge clock) disable iff (rst)
    !$isunknown(data_hits) |-> $onehot0(data_hits))
    else $error("tlb: data search matched more than one entry");

endmodule

// ==== verilog/addr_translator.sv ====
`include "tlb_macros.svh"

module addr_translator (
  input  logic                        clock,
  input  logic                        rst,
  input  mmu_pkg::translate_request_t request,
  input  logic [`ASID_W-1:0]          current_asid,
  output tlb_pkg::search_request_t    search,
  input  tlb_pkg::search_result_t     found,
  output mmu_pkg::translate_result_t  result
);
  mmu_pkg::exception_t exc;
  logic [31:0]         paddr;
  logic                valid_q;
  mmu_pkg::exception_t exc_q;
  logic [31:0]         paddr_q;

  always_comb begin
    search.virtual_page_number = request.vaddr[31:13];
    search.asid = current_asid;
    search.is_even_page = ~request.vaddr[12];
  end

  always_comb begin
    exc = mmu_pkg::exc_none;
    paddr = '0;
    if (!found.found) begin
      exc = mmu_pkg::exc_refill;
    end else if (!found.entry.valid) begin
      exc = mmu_pkg::exc_invalid;
    end else if (request.access == mmu_pkg::access_store && !found.entry.dirty) begin
      exc = mmu_pkg::exc_modified;  // Store to a clean page.
    end else begin
      paddr = {found.entry.pfn, request.vaddr[11:0]};
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= request.valid;
    end
  end

  always_ff @(posedge clock) begin
    exc_q <= exc;
    paddr_q <= paddr;
  end

  assign result = '{valid: valid_q, exception: exc_q, paddr: paddr_q};

endmodule

// ==== verilog/tlb_manager.sv ====
`include "tlb_macros.svh"

module tlb_manager (
  input  logic                    clock,
  input  logic                    rst,
  input  mmu_pkg::wb_request_t    wb,
  output logic [31:0]             wb_dat_o,
  output logic                    wb_ack,
  output logic [`ASID_W-1:0]      current_asid,
  output logic                    write_enabled,
  output logic [`TLB_INDEX_W-1:0] write_index,
  output tlb_pkg::tlb_entry_t     write_data,
  output logic [`TLB_INDEX_W-1:0] read_index,
  input  tlb_pkg::tlb_entry_t     read_data
);
  mmu_pkg::manager_state_t state_q;
  tlb_pkg::tlb_entry_t     staging_q;  // entry_hi, lo0 and lo1.
  logic [`TLB_INDEX_W-1:0] index_q;
  logic                    probe_fail_q;
  logic [`TLB_INDEX_W-1:0] probe_index_q;
  logic                    bus_access;
  logic [2:0]              word_sel;
  mmu_pkg::command_t       command;
  logic                    probe_hit;

  function automatic logic [31:0] page_word(input tlb_pkg::entry_t page);
    return {6'b0, page.pfn, 1'b0, page.cache, page.dirty, page.valid, 1'b0};
  endfunction

  function automatic tlb_pkg::entry_t word_page(input logic [31:0] word);
    return '{pfn: word[25:6], cache: word[4:3], dirty: word[2], valid: word[1]};
  endfunction

  assign bus_access = wb.cyc && wb.stb && state_q == mmu_pkg::state_idle;
  assign word_sel = wb.adr[4:2];
  assign command = mmu_pkg::command_t'(wb.dat[1:0]);
  assign probe_hit = read_data.virtual_page_number == staging_q.virtual_page_number &&
                     (read_data.asid == staging_q.asid || read_data.is_global);

  assign write_enabled = bus_access && wb.we && word_sel == 3'd4 &&
                         command == mmu_pkg::cmd_tlbwi;
  assign write_index = index_q;
  assign write_data = staging_q;
  assign read_index = (state_q == mmu_pkg::state_probing) ? probe_index_q : index_q;
  assign current_asid = staging_q.asid;
  assign wb_ack = state_q == mmu_pkg::state_acking;

  always_comb begin
    case (word_sel)
      3'd0: wb_dat_o = {probe_fail_q, {(31 - `TLB_INDEX_W){1'b0}}, index_q};
      3'd1: wb_dat_o = {staging_q.virtual_page_number, 4'b0, staging_q.is_global,
                        staging_q.asid};
      3'd2: wb_dat_o = page_word(staging_q.even_page);
      3'd3: wb_dat_o = page_word(staging_q.odd_page);
      default: wb_dat_o = '0;  // Command reads as zero.
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state_q <= mmu_pkg::state_idle;
      staging_q <= '0;
      index_q <= '0;
      probe_fail_q <= 1'b0;
      probe_index_q <= '0;
    end else begin
      case (state_q)
        mmu_pkg::state_idle: begin
          if (bus_access) begin
            state_q <= mmu_pkg::state_acking;
            if (wb.we) begin
              case (word_sel)
                3'd0: index_q <= wb.dat[`TLB_INDEX_W-1:0];
                3'd1: begin
                  staging_q.virtual_page_number <= wb.dat[31:13];
                  staging_q.is_global <= wb.dat[8];
                  staging_q.asid <= wb.dat[7:0];
                end
                3'd2: staging_q.even_page <= word_page(wb.dat);
                3'd3: staging_q.odd_page <= word_page(wb.dat);
                3'd4: begin
                  if (command == mmu_pkg::cmd_tlbr) begin
                    staging_q <= read_data;
                  end else if (command == mmu_pkg::cmd_tlbp) begin
                    state_q <= mmu_pkg::state_probing;  // Ack waits for the scan.
                    probe_index_q <= '0;
                  end
                end
                default: ;
              endcase
            end
          end
        end
        mmu_pkg::state_probing: begin
          if (probe_hit) begin
            index_q <= probe_index_q;
            probe_fail_q <= 1'b0;
            state_q <= mmu_pkg::state_acking;
          end else if (probe_index_q == (`TLB_NUM - 1)) begin
            probe_fail_q <= 1'b1;  // Index stays as it was.
            state_q <= mmu_pkg::state_acking;
          end else begin
            probe_index_q <= probe_index_q + 1'b1;
          end
        end
        default: state_q <= mmu_pkg::state_idle;
      endcase
    end
  end

  a_ack_in_cycle: assert property (@(posedge clock) disable iff (rst)
    wb_ack |-> wb.cyc && wb.stb)
    else $error("tlb_manager: ack outside a bus cycle");

  a_held_probing: assert property (@(posedge clock) disable iff (rst)
    state_q == mmu_pkg::state_probing |-> wb.cyc && wb.stb)
    else $error("tlb_manager: bus cycle dropped during probe");

endmodule

// ==== verilog/mmu_top.sv ====
`include "tlb_macros.svh"

module mmu_top (
  input  logic                        clock,
  input  logic                        rst,
  input  mmu_pkg::translate_request_t fetch_request,
  input  mmu_pkg::translate_request_t data_request,
  output mmu_pkg::translate_result_t  fetch_result,
  output mmu_pkg::translate_result_t  data_result,
  input  mmu_pkg::wb_request_t        wb,
  output logic [31:0]                 wb_dat_o,
  output logic                        wb_ack
);
  tlb_pkg::search_request_t fetch_search;
  tlb_pkg::search_request_t data_search;
  tlb_pkg::search_result_t  fetch_found;
  tlb_pkg::search_result_t  data_found;
  logic                     write_enabled;
  logic [`TLB_INDEX_W-1:0]  write_index;
  tlb_pkg::tlb_entry_t      write_data;
  logic [`TLB_INDEX_W-1:0]  read_index;
  tlb_pkg::tlb_entry_t      read_data;
  logic [`ASID_W-1:0]       current_asid;

  tlb tlb (
    .clock, .rst,
    .fetch_search, .data_search, .fetch_found, .data_found,
    .write_enabled, .write_index, .write_data,
    .read_index, .read_data
  );

  addr_translator fetch_translator (
    .clock, .rst, .request(fetch_request), .current_asid,
    .search(fetch_search), .found(fetch_found), .result(fetch_result)
  );

  addr_translator data_translator (
    .clock, .rst, .request(data_request), .current_asid,
    .search(data_search), .found(data_found), .result(data_result)
  );

  tlb_manager manager (
    .clock, .rst, .wb, .wb_dat_o, .wb_ack, .current_asid,
    .write_enabled, .write_index, .write_data, .read_index, .read_data
  );

endmodule

// ==== testbench/tb_mmu.sv ====
`include "tlb_macros.svh"

module tb_mmu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 20000;  // 300 bus ops of 20 cycles, 2000 translations, margin.
  localparam logic [31:0] ADR_INDEX = 32'd0;
  localparam logic [31:0] ADR_HI = 32'd4;
  localparam logic [31:0] ADR_LO0 = 32'd8;
  localparam logic [31:0] ADR_LO1 = 32'd12;
  localparam logic [31:0] ADR_CMD = 32'd16;
  localparam logic [31:0] IDLE_VADDR = 32'hffff_e000;  // No unwritten entry matches it.

  logic                        clock;
  logic                        rst;
  mmu_pkg::translate_request_t fetch_request;
  mmu_pkg::translate_request_t data_request;
  mmu_pkg::translate_result_t  fetch_result;
  mmu_pkg::translate_result_t  data_result;
  mmu_pkg::wb_request_t        wb;
  logic [31:0]                 wb_dat_o;
  logic                        wb_ack;

  tlb_pkg::tlb_entry_t     model [`TLB_NUM];
  bit                      filled [`TLB_NUM];
  logic [`ASID_W-1:0]      model_asid;
  logic [`TLB_INDEX_W-1:0] model_index;
  logic [`VPN2_W-1:0]      vpn_pool [8];
  logic [`ASID_W-1:0]      asid_pool [4];
  logic [31:0]             rng_state = 32'h6d9d1261;
  int                      cycles;
  int                      seen [4];  // Expected results per exception kind.

  mmu_top DUT (
    .clock, .rst, .fetch_request, .data_request, .fetch_result, .data_result,
    .wb, .wb_dat_o, .wb_ack
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES));
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  function logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic tlb_pkg::entry_t random_page();
    logic [31:0]     r;
    tlb_pkg::entry_t p;
    r = next_random();
    p.pfn = r[31:12];
    p.cache = r[5:4];
    p.dirty = r[0];
    p.valid = r[1] | r[2];  // Valid three times in four.
    return p;
  endfunction

  function automatic tlb_pkg::tlb_entry_t random_entry();
    logic [31:0]         r;
    tlb_pkg::tlb_entry_t e;
    r = next_random();
    e.virtual_page_number = vpn_pool[r[2:0]];
    e.asid = asid_pool[r[4:3]];
    e.is_global = r[10:8] == 3'd0;
    e.even_page = random_page();
    e.odd_page = random_page();
    return e;
  endfunction

  // A write conflicts when another entry would match the same page and ASID.
  function automatic bit conflicts(input tlb_pkg::tlb_entry_t e, input int idx);
    for (int j = 0; j < `TLB_NUM; j++) begin
      if (j != idx && filled[j] && model[j].virtual_page_number == e.virtual_page_number &&
          (model[j].asid == e.asid || model[j].is_global || e.is_global)) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic int model_lookup(input logic [`VPN2_W-1:0] vpn,
                                      input logic [`ASID_W-1:0] asid);
    for (int j = 0; j < `TLB_NUM; j++) begin
      if (filled[j] && model[j].virtual_page_number == vpn &&
          (model[j].asid == asid || model[j].is_global)) begin
        return j;
      end
    end
    return -1;
  endfunction

  function automatic mmu_pkg::translate_result_t expected_result(
    input mmu_pkg::translate_request_t req
  );
    int                         hit;
    tlb_pkg::entry_t            page;
    mmu_pkg::translate_result_t res;
    res = '0;
    res.valid = req.valid;
    hit = model_lookup(req.vaddr[31:13], model_asid);
    if (hit < 0) begin
      res.exception = mmu_pkg::exc_refill;
    end else begin
      page = req.vaddr[12] ? model[hit].odd_page : model[hit].even_page;
      if (!page.valid) res.exception = mmu_pkg::exc_invalid;
      else if (req.access == mmu_pkg::access_store && !page.dirty)
        res.exception = mmu_pkg::exc_modified;
      else res.paddr = {page.pfn, req.vaddr[11:0]};
    end
    return res;
  endfunction

  function automatic mmu_pkg::translate_request_t random_request(input bit data_side);
    logic [31:0]                 r;
    logic [31:0]                 s;
    mmu_pkg::translate_request_t q;
    r = next_random();
    s = next_random();
    q.valid = 1'b1;
    if (!data_side) q.access = mmu_pkg::access_fetch;
    else if (r[0]) q.access = mmu_pkg::access_store;
    else q.access = mmu_pkg::access_load;
    if (r[7:5] == 3'd0) q.vaddr = s;  // Almost surely unmapped.
    else q.vaddr = {vpn_pool[r[4:2]], s[12:0]};
    return q;
  endfunction

  task automatic check_translation(input string what, input mmu_pkg::translate_result_t act,
                                   input mmu_pkg::translate_result_t exp);
    if (act.valid !== exp.valid || (exp.valid && act !== exp)) begin
      abort_run($sformatf("error %0t: %s expected valid %b exc %0d paddr %h, got %b %0d %h",
        $time, what, exp.valid, exp.exception, exp.paddr, act.valid, act.exception, act.paddr));
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("error %0t: %s expected %h got %h", $time, what, exp, act));
    end
  endtask

  task automatic check_entry(input string what, input tlb_pkg::tlb_entry_t act,
                             input tlb_pkg::tlb_entry_t exp);
    if (act !== exp) begin
      abort_run($sformatf("error %0t: %s expected %h got %h", $time, what, exp, act));
    end
  endtask

  // Classic cycle; ack is sampled on the falling edge.
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    @(posedge clock);
    wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do @(negedge clock); while (!wb_ack);
    rdata = wb_dat_o;
    @(posedge clock);
    wb <= '0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, 32'd0, dat);
  endtask

  function automatic logic [31:0] lo_word(input tlb_pkg::entry_t p);
    return {6'b0, p.pfn, 1'b0, p.cache, p.dirty, p.valid, 1'b0};
  endfunction

  function automatic tlb_pkg::entry_t lo_page(input logic [31:0] w);
    return '{pfn: w[25:6], cache: w[4:3], dirty: w[2], valid: w[1]};
  endfunction

  task automatic write_entry(input int idx, input tlb_pkg::tlb_entry_t e);
    wb_write(ADR_INDEX, 32'(idx));
    wb_write(ADR_HI, {e.virtual_page_number, 4'b0, e.is_global, e.asid});
    wb_write(ADR_LO0, lo_word(e.even_page));
    wb_write(ADR_LO1, lo_word(e.odd_page));
    wb_write(ADR_CMD, 32'(mmu_pkg::cmd_tlbwi));
    model[idx] = e;
    filled[idx] = 1'b1;
    model_asid = e.asid;  // Entry_hi is also the current ASID.
    model_index = idx[`TLB_INDEX_W-1:0];
  endtask

  task automatic place_entry(input int idx);
    tlb_pkg::tlb_entry_t e;
    int                  tries;
    tries = 0;
    e = random_entry();
    while (conflicts(e, idx)) begin
      tries++;
      if (tries > 1000) abort_run("Could not find a unique mapping for a table entry.");
      e = random_entry();
    end
    write_entry(idx, e);
  endtask

  task automatic read_back(input int idx);
    logic [31:0]         hi;
    logic [31:0]         lo0;
    logic [31:0]         lo1;
    tlb_pkg::tlb_entry_t got;
    wb_write(ADR_INDEX, 32'(idx));
    wb_write(ADR_CMD, 32'(mmu_pkg::cmd_tlbr));
    wb_read(ADR_HI, hi);
    wb_read(ADR_LO0, lo0);
    wb_read(ADR_LO1, lo1);
    got = '{virtual_page_number: hi[31:13], asid: hi[7:0], is_global: hi[8],
            even_page: lo_page(lo0), odd_page: lo_page(lo1)};
    check_entry($sformatf("entry %0d after tlbr", idx), got, model[idx]);
    model_asid = model[idx].asid;
  endtask

  task automatic set_asid(input logic [`ASID_W-1:0] asid);
    wb_write(ADR_HI, {24'b0, asid});
    model_asid = asid;
  endtask

  task automatic probe(input logic [`VPN2_W-1:0] vpn, input logic [`ASID_W-1:0] asid);
    logic [31:0] word;
    logic [31:0] exp;
    int          hit;
    wb_write(ADR_HI, {vpn, 5'b0, asid});
    model_asid = asid;
    wb_write(ADR_CMD, 32'(mmu_pkg::cmd_tlbp));
    wb_read(ADR_INDEX, word);
    hit = model_lookup(vpn, asid);
    if (hit >= 0) model_index = hit[`TLB_INDEX_W-1:0];
    exp = {hit < 0, 27'b0, model_index};  // Failure keeps the old index.
    check_word("index after tlbp", word, exp);
  endtask

  // Each result is checked one cycle after its request.
  task automatic run_translations(input int n);
    mmu_pkg::translate_request_t f;
    mmu_pkg::translate_request_t d;
    mmu_pkg::translate_result_t  exp_f;
    mmu_pkg::translate_result_t  exp_d;
    exp_f = '0;
    exp_d = '0;
    for (int i = 0; i <= n; i++) begin
      @(posedge clock);
      if (i < n) begin
        f = random_request(1'b0);
        d = random_request(1'b1);
      end else begin
        f = '{valid: 1'b0, access: mmu_pkg::access_fetch, vaddr: IDLE_VADDR};
        d = f;
      end
      fetch_request <= f;
      data_request <= d;
      @(negedge clock);
      check_translation("fetch translation", fetch_result, exp_f);
      check_translation("data translation", data_result, exp_d);
      exp_f = expected_result(f);
      exp_d = expected_result(d);
      if (exp_f.valid) seen[exp_f.exception]++;
      if (exp_d.valid) seen[exp_d.exception]++;
    end
  endtask

  initial begin
    logic [31:0]         r;
    logic [`VPN2_W-1:0]  absent_vpn;
    rst = 1'b1;
    fetch_request = '{valid: 1'b0, access: mmu_pkg::access_fetch, vaddr: IDLE_VADDR};
    data_request = fetch_request;
    wb = '0;
    for (int k = 0; k < 8; k++) begin
      r = next_random();
      vpn_pool[k] = r[`VPN2_W-1:0];
    end
    asid_pool = '{8'h11, 8'h22, 8'h33, 8'h44};
    repeat (2) @(posedge clock);
    rst <= 1'b0;

    for (int i = 0; i < `TLB_NUM; i++) place_entry(i);
    for (int i = 0; i < `TLB_NUM; i++) read_back(i);

    set_asid(asid_pool[0]);
    run_translations(500);
    set_asid(asid_pool[1]);  // Old non-global mappings now refill.
    run_translations(500);

    probe(model[6].virtual_page_number, model[6].asid);
    wb_write(ADR_INDEX, 32'd9);
    model_index = 4'd9;
    do begin
      r = next_random();
      absent_vpn = r[`VPN2_W-1:0];
    end while (model_lookup(absent_vpn, asid_pool[2]) >= 0);
    probe(absent_vpn, asid_pool[2]);

    set_asid(asid_pool[0]);
    run_translations(200);
    place_entry(3);
    run_translations(200);

    if (seen[0] == 0 || seen[1] == 0 || seen[2] == 0 || seen[3] == 0) begin
      abort_run("Not every exception kind came up in the translations.");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/tlb_pkg.sv
verilog/mmu_pkg.sv
verilog/tlb.sv
verilog/addr_translator.sv
verilog/tlb_manager.sv
verilog/mmu_top.sv
testbench/tb_mmu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mmu
BUILD_DIR ?= build
FLIST ?= flist.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(FLIST) $(wildcard verilog/*.sv verilog/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FLIST)

run: $(SIM)
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)
